/* cache_geom_pkg.sv */
// single fixed geometry for every module; num_ways must stay a power of two
package cache_geom_pkg;

	// sets per way
	localparam int num_sets = 16;
	localparam int set_bits = $clog2(num_sets);

	// associativity
	localparam int num_ways = 4;
	localparam int way_bits = $clog2(num_ways);

	// tag and line widths
	localparam int tag_bits = 8;
	localparam int data_bits = 64;

endpackage

/* plru_pkg.sv */
// tree PLRU sizing, valid only for a power-of-two way count
package plru_pkg;

	import cache_geom_pkg::*;

	// internal nodes of a full binary tree over the ways
	localparam int tree_bits = num_ways - 1;

	// levels walked from root to leaf
	localparam int tree_depth = way_bits;

endpackage

/* cache_way.sv */
// one way over all sets; lookups are combinational and a strobe lands at the next clock edge
`timescale 1ns/1ps

module cache_way import cache_geom_pkg::*; (
	input logic clock,
	input logic reset,

	input logic wr_strobe,
	input logic [set_bits-1:0] wr_idx,
	input logic [tag_bits-1:0] wr_tag,
	input logic [data_bits-1:0] wr_data,

	input logic [set_bits-1:0] rd_idx,
	input logic [tag_bits-1:0] rd_tag,

	output logic rd_hit,
	output logic wr_hit,
	output logic wr_line_valid,
	output logic [tag_bits-1:0] wr_line_tag,
	output logic [data_bits-1:0] wr_line_data,
	output logic [data_bits-1:0] rd_line_data
);

	logic [num_sets-1:0] valid;
	logic [tag_bits-1:0] tags [num_sets];
	logic [data_bits-1:0] lines [num_sets];

	// valid bits
	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else if (wr_strobe) begin
			valid[wr_idx] <= 1'b1;
		end
	end

	// tag and data storage
	always_ff @(posedge clock) begin
		if (wr_strobe) begin
			tags[wr_idx] <= wr_tag;
			lines[wr_idx] <= wr_data;
		end
	end

	// write-side lookup
	assign wr_line_valid = valid[wr_idx];
	assign wr_line_tag = tags[wr_idx];
	assign wr_line_data = lines[wr_idx];
	assign wr_hit = wr_line_valid && (wr_line_tag == wr_tag);

	// read-side lookup
	assign rd_line_data = lines[rd_idx];
	assign rd_hit = valid[rd_idx] && (tags[rd_idx] == rd_tag);

endmodule

/* fill_way_select.sv */
// picks the hit way, else the lowest invalid way, else the PLRU victim; one strobe per write
`timescale 1ns/1ps

module fill_way_select import cache_geom_pkg::*; (
	input logic wr_en,
	input logic [num_ways-1:0] wr_hits,
	input logic [num_ways-1:0] wr_valids,
	input logic [way_bits-1:0] plru_victim,

	output logic [num_ways-1:0] wr_strobes,
	output logic [way_bits-1:0] fill_way,
	output logic wr_hit_any
);

	logic [way_bits-1:0] hit_way;
	logic [way_bits-1:0] free_way;
	logic any_free;

	// at most one way can hit
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < num_ways; w++) begin
			if (wr_hits[w]) begin
				hit_way = way_bits'(w);
			end
		end
	end

	// walk down so the lowest invalid way wins
	always_comb begin
		free_way = '0;
		for (int w = num_ways - 1; w >= 0; w--) begin
			if (!wr_valids[w]) begin
				free_way = way_bits'(w);
			end
		end
	end

	assign any_free = ~&wr_valids;
	assign wr_hit_any = |wr_hits;

	always_comb begin
		if (wr_hit_any) begin
			fill_way = hit_way;
		end else if (any_free) begin
			fill_way = free_way;
		end else begin
			fill_way = plru_victim;
		end
	end

	assign wr_strobes = wr_en ? (num_ways'(1) << fill_way) : '0;

endmodule

/* plru_tree.sv */
// tree bits per set; a write touch is applied before a read touch of the same set
`timescale 1ns/1ps

module plru_tree import cache_geom_pkg::*, plru_pkg::*; (
	input logic clock,
	input logic reset,

	input logic wr_en,
	input logic [set_bits-1:0] wr_idx,
	input logic [way_bits-1:0] fill_way,

	input logic rd_en,
	input logic [set_bits-1:0] rd_idx,
	input logic [num_ways-1:0] rd_hits,

	output logic [way_bits-1:0] plru_victim
);

	logic [num_sets-1:0][tree_bits-1:0] tree;
	logic [num_sets-1:0][tree_bits-1:0] tree_next;
	logic [way_bits-1:0] rd_way;

	// point every node on the path away from the touched way
	function automatic logic [tree_bits-1:0] touch(
		input logic [tree_bits-1:0] bits,
		input logic [way_bits-1:0] way
	);
		logic [tree_bits-1:0] result;
		int node;
		logic dir;
		result = bits;
		node = 0;
		for (int level = 0; level < tree_depth; level++) begin
			dir = way[way_bits-1-level];
			result[node] = ~dir;
			node = 2 * node + 1 + int'(dir);
		end
		return result;
	endfunction

	always_comb begin
		rd_way = '0;
		for (int w = 0; w < num_ways; w++) begin
			if (rd_hits[w]) begin
				rd_way = way_bits'(w);
			end
		end
	end

	// follow the node bits of the write set, 0 goes left
	always_comb begin
		int node;
		logic dir;
		node = 0;
		plru_victim = '0;
		for (int level = 0; level < tree_depth; level++) begin
			dir = tree[wr_idx][node];
			plru_victim[way_bits-1-level] = dir;
			node = 2 * node + 1 + int'(dir);
		end
	end

	always_comb begin
		tree_next = tree;
		if (wr_en) begin
			tree_next[wr_idx] = touch(tree_next[wr_idx], fill_way);
		end
		if (rd_en && |rd_hits) begin
			tree_next[rd_idx] = touch(tree_next[rd_idx], rd_way);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			tree <= '0;
		end else begin
			tree <= tree_next;
		end
	end

endmodule

/* read_merge.sv */
// read data is valid only with rd_en; a same index and tag write bypasses into the read
`timescale 1ns/1ps

module read_merge import cache_geom_pkg::*; (
	input logic rd_en,
	input logic [set_bits-1:0] rd_idx,
	input logic [tag_bits-1:0] rd_tag,
	input logic [num_ways-1:0] rd_hits,
	input logic [num_ways-1:0][data_bits-1:0] rd_line_data,

	input logic wr_en,
	input logic [set_bits-1:0] wr_idx,
	input logic [tag_bits-1:0] wr_tag,
	input logic [data_bits-1:0] wr_data,
	input logic wr_hit_any,
	input logic [way_bits-1:0] fill_way,
	input logic [num_ways-1:0] wr_line_valid,
	input logic [num_ways-1:0][tag_bits-1:0] wr_line_tag,
	input logic [num_ways-1:0][data_bits-1:0] wr_line_data,

	output logic [data_bits-1:0] rd_data,
	output logic rd_valid,
	output logic miss_rd,
	output logic miss_wr,
	output logic victim_valid,
	output logic [tag_bits-1:0] victim_tag,
	output logic [data_bits-1:0] victim_data
);

	logic bypass;
	logic [data_bits-1:0] hit_data;

	assign bypass = rd_en && wr_en && (rd_idx == wr_idx) && (rd_tag == wr_tag);

	// and-or mux, hits are one-hot
	always_comb begin
		hit_data = '0;
		for (int w = 0; w < num_ways; w++) begin
			hit_data = hit_data | (rd_line_data[w] & {data_bits{rd_hits[w]}});
		end
	end

	assign rd_data = bypass ? wr_data : hit_data;
	assign rd_valid = bypass || (rd_en && |rd_hits);
	assign miss_rd = rd_en && !rd_valid;

	assign miss_wr = wr_en && !wr_hit_any;

	// a free way is always chosen first, so a valid fill way means eviction
	assign victim_valid = miss_wr && wr_line_valid[fill_way];
	assign victim_tag = wr_line_tag[fill_way];
	assign victim_data = wr_line_data[fill_way];

endmodule

/* set_assoc_cache.sv */
// set-associative cache with tree PLRU, no refill side; every cycle is accepted
`timescale 1ns/1ps

module set_assoc_cache import cache_geom_pkg::*; (
	input logic clock,
	input logic reset,

	input logic wr_en,
	input logic [set_bits-1:0] wr_idx,
	input logic [tag_bits-1:0] wr_tag,
	input logic [data_bits-1:0] wr_data,

	input logic rd_en,
	input logic [set_bits-1:0] rd_idx,
	input logic [tag_bits-1:0] rd_tag,

	output logic [data_bits-1:0] rd_data,
	output logic rd_valid,
	output logic miss_rd,
	output logic miss_wr,
	output logic victim_valid,
	output logic [tag_bits-1:0] victim_tag,
	output logic [data_bits-1:0] victim_data
);

	logic [num_ways-1:0] rd_hits;
	logic [num_ways-1:0] wr_hits;
	logic [num_ways-1:0] wr_line_valid;
	logic [num_ways-1:0][tag_bits-1:0] wr_line_tag;
	logic [num_ways-1:0][data_bits-1:0] wr_line_data;
	logic [num_ways-1:0][data_bits-1:0] rd_line_data;
	logic [num_ways-1:0] wr_strobes;
	logic [way_bits-1:0] fill_way;
	logic [way_bits-1:0] plru_victim;
	logic wr_hit_any;

	fill_way_select i_fill (
		.wr_en(wr_en),
		.wr_hits(wr_hits),
		.wr_valids(wr_line_valid),
		.plru_victim(plru_victim),
		.wr_strobes(wr_strobes),
		.fill_way(fill_way),
		.wr_hit_any(wr_hit_any)
	);

	for (genvar w = 0; w < num_ways; w++) begin : g_way
		cache_way i_way (
			.clock(clock),
			.reset(reset),
			.wr_strobe(wr_strobes[w]),
			.wr_idx(wr_idx),
			.wr_tag(wr_tag),
			.wr_data(wr_data),
			.rd_idx(rd_idx),
			.rd_tag(rd_tag),
			.rd_hit(rd_hits[w]),
			.wr_hit(wr_hits[w]),
			.wr_line_valid(wr_line_valid[w]),
			.wr_line_tag(wr_line_tag[w]),
			.wr_line_data(wr_line_data[w]),
			.rd_line_data(rd_line_data[w])
		);
	end

	plru_tree i_plru (
		.clock(clock),
		.reset(reset),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.fill_way(fill_way),
		.rd_en(rd_en),
		.rd_idx(rd_idx),
		.rd_hits(rd_hits),
		.plru_victim(plru_victim)
	);

	read_merge i_merge (
		.rd_en(rd_en),
		.rd_idx(rd_idx),
		.rd_tag(rd_tag),
		.rd_hits(rd_hits),
		.rd_line_data(rd_line_data),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_tag(wr_tag),
		.wr_data(wr_data),
		.wr_hit_any(wr_hit_any),
		.fill_way(fill_way),
		.wr_line_valid(wr_line_valid),
		.wr_line_tag(wr_line_tag),
		.wr_line_data(wr_line_data),
		.rd_data(rd_data),
		.rd_valid(rd_valid),
		.miss_rd(miss_rd),
		.miss_wr(miss_wr),
		.victim_valid(victim_valid),
		.victim_tag(victim_tag),
		.victim_data(victim_data)
	);

endmodule

/* tb_set_assoc_cache.sv */
// directed tests plus a seeded random mix; also peeks at i_dut.fill_way to check fill order
`timescale 1ns/1ps

module tb_set_assoc_cache import cache_geom_pkg::*, plru_pkg::*; ();

	// reset, then the tests in order: 5, 8, 3, 10, 3 and 300 cycles
	localparam int test_cycles = 10 + 5 + 8 + 3 + 10 + 3 + 300;
	localparam int cycle_limit = 2 * test_cycles;
	localparam logic [set_bits-1:0] mix_set_a = 3;
	localparam logic [set_bits-1:0] mix_set_b = 9;

	logic clock;
	logic reset;
	logic wr_en;
	logic [set_bits-1:0] wr_idx;
	logic [tag_bits-1:0] wr_tag;
	logic [data_bits-1:0] wr_data;
	logic rd_en;
	logic [set_bits-1:0] rd_idx;
	logic [tag_bits-1:0] rd_tag;
	logic [data_bits-1:0] rd_data;
	logic rd_valid;
	logic miss_rd;
	logic miss_wr;
	logic victim_valid;
	logic [tag_bits-1:0] victim_tag;
	logic [data_bits-1:0] victim_data;

	// reference model of the cache contents
	logic [num_ways-1:0] m_valid [num_sets];
	logic [tag_bits-1:0] m_tag [num_sets][num_ways];
	logic [data_bits-1:0] m_data [num_sets][num_ways];
	logic [tree_bits-1:0] m_tree [num_sets];

	logic [31:0] lfsr_state = 32'h9dd0df37;
	int checks = 0;
	int errors = 0;
	int cycle_count = 0;

	set_assoc_cache i_dut (
		.clock(clock),
		.reset(reset),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_tag(wr_tag),
		.wr_data(wr_data),
		.rd_en(rd_en),
		.rd_idx(rd_idx),
		.rd_tag(rd_tag),
		.rd_data(rd_data),
		.rd_valid(rd_valid),
		.miss_rd(miss_rd),
		.miss_wr(miss_wr),
		.victim_valid(victim_valid),
		.victim_tag(victim_tag),
		.victim_data(victim_data)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout, the tests did not finish within %0d cycles", cycle_limit);
			$display("checks: %0d  errors: %0d", checks, errors);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// galois form, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	function automatic logic [63:0] random_bits(input int count);
		logic [63:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[62:0], lfsr_state[0]};
		end
		return bits;
	endfunction

	task automatic expect_equal(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, expected);
		end
	endtask

	function automatic int find_way(input logic [set_bits-1:0] idx,
			input logic [tag_bits-1:0] tag);
		int found;
		found = -1;
		for (int w = 0; w < num_ways; w++) begin
			if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
				found = w;
			end
		end
		return found;
	endfunction

	function automatic int lowest_free(input logic [set_bits-1:0] idx);
		int found;
		found = -1;
		for (int w = num_ways - 1; w >= 0; w--) begin
			if (!m_valid[idx][w]) begin
				found = w;
			end
		end
		return found;
	endfunction

	// narrow the way range half by half, a 0 bit keeps the left half
	function automatic int model_victim(input logic [set_bits-1:0] idx);
		int lo;
		int hi;
		int node;
		lo = 0;
		hi = num_ways;
		node = 0;
		for (int level = 0; level < tree_depth; level++) begin
			if (m_tree[idx][node]) begin
				lo = (lo + hi) / 2;
				node = 2 * node + 2;
			end else begin
				hi = (lo + hi) / 2;
				node = 2 * node + 1;
			end
		end
		return lo;
	endfunction

	task automatic model_touch(input logic [set_bits-1:0] idx, input int way);
		int lo;
		int hi;
		int mid;
		int node;
		lo = 0;
		hi = num_ways;
		node = 0;
		for (int level = 0; level < tree_depth; level++) begin
			mid = (lo + hi) / 2;
			if (way < mid) begin
				m_tree[idx][node] = 1'b1;
				node = 2 * node + 1;
				hi = mid;
			end else begin
				m_tree[idx][node] = 1'b0;
				node = 2 * node + 2;
				lo = mid;
			end
		end
	endtask

	// one cycle: drive on the falling edge, check in the low phase, then advance the model
	task automatic run_cycle(input logic we, input logic [set_bits-1:0] widx,
			input logic [tag_bits-1:0] wtag, input logic [data_bits-1:0] wdata,
			input logic re, input logic [set_bits-1:0] ridx, input logic [tag_bits-1:0] rtag);
		int w_hit;
		int r_hit;
		int free_way;
		int vic;
		int fill;
		logic exp_rd_valid;
		logic exp_miss_wr;
		logic exp_victim_valid;
		logic bypass;
		@(negedge clock);
		wr_en = we;
		wr_idx = widx;
		wr_tag = wtag;
		wr_data = wdata;
		rd_en = re;
		rd_idx = ridx;
		rd_tag = rtag;
		#1;
		w_hit = find_way(widx, wtag);
		r_hit = find_way(ridx, rtag);
		free_way = lowest_free(widx);
		vic = model_victim(widx);
		fill = (w_hit >= 0) ? w_hit : ((free_way >= 0) ? free_way : vic);
		bypass = re && we && ridx == widx && rtag == wtag;
		exp_rd_valid = bypass || (re && r_hit >= 0);
		exp_miss_wr = we && w_hit < 0;
		exp_victim_valid = exp_miss_wr && free_way < 0;
		expect_equal("rd_valid", 64'(rd_valid), 64'(exp_rd_valid));
		expect_equal("miss_rd", 64'(miss_rd), 64'(re && !exp_rd_valid));
		expect_equal("miss_wr", 64'(miss_wr), 64'(exp_miss_wr));
		expect_equal("victim_valid", 64'(victim_valid), 64'(exp_victim_valid));
		if (exp_rd_valid) begin
			expect_equal("rd_data", rd_data, bypass ? wdata : m_data[ridx][r_hit]);
		end
		if (exp_victim_valid) begin
			expect_equal("victim_tag", 64'(victim_tag), 64'(m_tag[widx][vic]));
			expect_equal("victim_data", victim_data, m_data[widx][vic]);
		end
		if (we) begin
			expect_equal("fill_way", 64'(i_dut.fill_way), 64'(fill));
			m_valid[widx][fill] = 1'b1;
			m_tag[widx][fill] = wtag;
			m_data[widx][fill] = wdata;
			model_touch(widx, fill);
		end
		// read touch lands after the write touch
		if (re && r_hit >= 0) begin
			model_touch(ridx, r_hit);
		end
	endtask

	task automatic write_line(input logic [set_bits-1:0] idx, input logic [tag_bits-1:0] tag,
			input logic [data_bits-1:0] data);
		run_cycle(1'b1, idx, tag, data, 1'b0, '0, '0);
	endtask

	task automatic read_line(input logic [set_bits-1:0] idx, input logic [tag_bits-1:0] tag);
		run_cycle(1'b0, '0, '0, '0, 1'b1, idx, tag);
	endtask

	task automatic idle_after_reset();
		run_cycle(1'b0, '0, '0, '0, 1'b0, '0, '0);
		read_line(0, 8'h11);
		expect_equal("miss_rd", 64'(miss_rd), 64'd1);
		read_line(6, 8'h11);
		expect_equal("rd_valid", 64'(rd_valid), 64'd0);
		read_line(15, 8'hff);
		expect_equal("miss_rd", 64'(miss_rd), 64'd1);
		run_cycle(1'b0, '0, '0, '0, 1'b0, '0, '0);
	endtask

	task automatic fill_and_read_back();
		logic [data_bits-1:0] lines [num_ways];
		for (int w = 0; w < num_ways; w++) begin
			lines[w] = random_bits(64);
			write_line(4, tag_bits'(32'hc0 + w), lines[w]);
			expect_equal("fill_way", 64'(i_dut.fill_way), 64'(w));
			expect_equal("victim_valid", 64'(victim_valid), 64'd0);
		end
		for (int w = 0; w < num_ways; w++) begin
			read_line(4, tag_bits'(32'hc0 + w));
			expect_equal("rd_data", rd_data, lines[w]);
		end
	endtask

	task automatic overwrite_on_hit();
		logic [data_bits-1:0] new_data;
		new_data = random_bits(64);
		write_line(2, 8'h31, random_bits(64));
		write_line(2, 8'h31, new_data);
		expect_equal("miss_wr", 64'(miss_wr), 64'd0);
		expect_equal("victim_valid", 64'(victim_valid), 64'd0);
		read_line(2, 8'h31);
		expect_equal("rd_data", rd_data, new_data);
	endtask

	task automatic plru_eviction();
		logic [data_bits-1:0] lines [num_ways];
		logic [data_bits-1:0] new_data;
		for (int w = 0; w < num_ways; w++) begin
			lines[w] = random_bits(64);
			write_line(5, tag_bits'(32'ha0 + w), lines[w]);
		end
		read_line(5, 8'ha2);
		read_line(5, 8'ha0);
		read_line(5, 8'ha3);
		// after touching ways 2, 0 and 3 the tree points at way 1
		new_data = random_bits(64);
		write_line(5, 8'ha4, new_data);
		expect_equal("victim_valid", 64'(victim_valid), 64'd1);
		expect_equal("victim_tag", 64'(victim_tag), 64'ha1);
		expect_equal("victim_data", victim_data, lines[1]);
		read_line(5, 8'ha1);
		expect_equal("rd_valid", 64'(rd_valid), 64'd0);
		read_line(5, 8'ha4);
		expect_equal("rd_data", rd_data, new_data);
	endtask

	task automatic same_cycle_bypass();
		logic [data_bits-1:0] first;
		logic [data_bits-1:0] second;
		first = random_bits(64);
		second = random_bits(64);
		run_cycle(1'b1, 9, 8'h5a, first, 1'b1, 9, 8'h5a);
		expect_equal("rd_valid", 64'(rd_valid), 64'd1);
		expect_equal("rd_data", rd_data, first);
		run_cycle(1'b1, 9, 8'h5a, second, 1'b1, 9, 8'h5a);
		expect_equal("rd_data", rd_data, second);
		read_line(9, 8'h5a);
		expect_equal("rd_data", rd_data, second);
	endtask

	task automatic random_mix();
		logic we;
		logic re;
		logic [set_bits-1:0] widx;
		logic [set_bits-1:0] ridx;
		logic [tag_bits-1:0] wtag;
		logic [tag_bits-1:0] rtag;
		logic [data_bits-1:0] wdata;
		for (int i = 0; i < 300; i++) begin
			we = random_bits(1) != 0;
			widx = (random_bits(1) != 0) ? mix_set_b : mix_set_a;
			wtag = tag_bits'(64'h70 + random_bits(3));
			wdata = random_bits(64);
			re = random_bits(1) != 0;
			ridx = (random_bits(1) != 0) ? mix_set_b : mix_set_a;
			rtag = tag_bits'(64'h70 + random_bits(3));
			run_cycle(we, widx, wtag, wdata, re, ridx, rtag);
		end
	endtask

	initial begin
		reset = 1'b1;
		wr_en = 1'b0;
		wr_idx = '0;
		wr_tag = '0;
		wr_data = '0;
		rd_en = 1'b0;
		rd_idx = '0;
		rd_tag = '0;
		for (int s = 0; s < num_sets; s++) begin
			m_valid[s] = '0;
			m_tree[s] = '0;
			for (int w = 0; w < num_ways; w++) begin
				m_tag[s][w] = '0;
				m_data[s][w] = '0;
			end
		end
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		idle_after_reset();
		fill_and_read_back();
		overwrite_on_hit();
		plru_eviction();
		same_cycle_bypass();
		random_mix();

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* set_assoc_cache.f */
cache_geom_pkg.sv
plru_pkg.sv
cache_way.sv
fill_way_select.sv
plru_tree.sv
read_merge.sv
set_assoc_cache.sv
tb_set_assoc_cache.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f set_assoc_cache.f \
	--top-module tb_set_assoc_cache -o sim_cache
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/sim_cache)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q '^RESULT: PASS$'; then
	exit 0
fi
exit 1
